/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_csr_unit
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Pass message missing from $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/csr_tb_model.svh */
`ifndef CSR_TB_MODEL_SVH
`define CSR_TB_MODEL_SVH

// Implemented fields of each register
localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_0088;
localparam logic [XLEN-1:0] INT_MASK     = 32'h0000_0808; // mie and mip
localparam logic [XLEN-1:0] MEPC_MASK    = 32'hFFFF_FFFC;
localparam logic [XLEN-1:0] MCAUSE_MASK  = 32'h8000_000F;

logic [XLEN-1:0] m_mstatus;
logic [XLEN-1:0] m_mie;
logic [XLEN-1:0] m_mepc;
logic [XLEN-1:0] m_mcause;
logic [XLEN-1:0] m_mip;

function automatic void clear_model();
    m_mstatus = '0;
    m_mie     = '0;
    m_mepc    = '0;
    m_mcause  = '0;
    m_mip     = '0;
endfunction

function automatic logic [XLEN-1:0] csr_value(input logic [2:0] a);
    case (a)
        MSTATUS: return m_mstatus;
        HANDLER: return HANDLER_VALUE;
        MIE:     return m_mie;
        MEPC:    return m_mepc;
        MCAUSE:  return m_mcause;
        MIP:     return m_mip;
        default: return '0;
    endcase
endfunction

function automatic logic [XLEN-1:0] expected_read(input csr_op_e o,
                                                  input logic [AE_W-1:0] ae);
    case (o)
        EXCEPTION:           return HANDLER_VALUE;
        MRET:                return m_mepc;
        CSRRW, CSRRS, CSRRC: return csr_value(ae[2:0]);
        default:             return '0;
    endcase
endfunction

function automatic void apply_update(input csr_op_e o, input logic [AE_W-1:0] ae,
                                     input logic [XLEN-1:0] wv);
    logic [XLEN-1:0] sel;
    logic [XLEN-1:0] nv;
    sel = csr_value(ae[2:0]);
    case (o)
        CSRRS:   nv = sel | wv;
        CSRRC:   nv = sel & ~wv;
        default: nv = wv;
    endcase
    if (o == EXCEPTION) begin
        m_mstatus = m_mstatus[MSTATUS_MIE_BIT] ? 32'h0000_0080 : 32'h0000_0000;
        m_mepc    = wv & MEPC_MASK;
        m_mcause  = {ae[AE_INT_BIT], 27'd0, ae[3:0]};
        if (ae[AE_INT_BIT] && ae[3:0] == 4'd3)
            m_mip[MIP_SW_BIT] = 1'b0;
        if (ae[AE_INT_BIT] && ae[3:0] == 4'd11)
            m_mip[MIP_EXT_BIT] = 1'b0;
    end else if (o == MRET) begin
        m_mstatus[MSTATUS_MIE_BIT] = m_mstatus[MSTATUS_MPIE_BIT];
    end else begin
        case (ae[2:0])
            MSTATUS: m_mstatus = nv & MSTATUS_MASK;
            MIE:     m_mie     = nv & INT_MASK;
            MEPC:    m_mepc    = nv & MEPC_MASK;
            MCAUSE:  m_mcause  = nv & MCAUSE_MASK;
            MIP:     m_mip     = nv & INT_MASK;
            default: ; // Handler address and unmapped codes ignore writes
        endcase
    end
endfunction

function automatic logic sw_pending_expected();
    return m_mip[3] & m_mie[3] & m_mstatus[3];
endfunction

function automatic logic ext_pending_expected();
    return m_mip[11] & m_mie[11] & m_mstatus[3];
endfunction

`endif

/* dv/tb_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    localparam logic [XLEN-1:0] HANDLER_VALUE = 32'h0000_0140;
    localparam int TEST_CYCLES    = 1000; // About 200 ops of 3 cycles plus pulses
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic            clk;
    logic            reset;
    logic            enable;
    logic            is_write_stage;
    csr_op_e         op;
    logic [AE_W-1:0] addr_exception;
    logic [XLEN-1:0] write_value;
    logic            ext_int;
    logic [XLEN-1:0] read_value;
    logic            sw_int_pending;
    logic            ext_int_pending;

    int        error_count;
    int        check_count;
    int        cycle_count;
    csr_addr_e reg_list [5];
    csr_op_e   op_list [3];

    `include "csr_tb_model.svh"

    csr_unit #(
        .HANDLER_ADDR (HANDLER_VALUE)
    ) u_csr_unit (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .is_write_stage  (is_write_stage),
        .op              (op),
        .addr_exception  (addr_exception),
        .write_value     (write_value),
        .ext_int         (ext_int),
        .read_value      (read_value),
        .sw_int_pending  (sw_int_pending),
        .ext_int_pending (ext_int_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_pending();
        check_flag("sw_int_pending", sw_int_pending, sw_pending_expected());
        check_flag("ext_int_pending", ext_int_pending, ext_pending_expected());
    endtask

    // Read stage then write stage, returns at the falling edge after the write edge
    task automatic run_op(input csr_op_e o, input logic [AE_W-1:0] ae,
                          input logic [XLEN-1:0] wv, output logic [XLEN-1:0] rd);
        logic [XLEN-1:0] exp_rd;
        exp_rd = expected_read(o, ae);
        @(negedge clk);
        enable         = 1'b1;
        is_write_stage = 1'b0;
        op             = o;
        addr_exception = ae;
        write_value    = wv;
        @(negedge clk);
        is_write_stage = 1'b1;
        rd             = read_value;
        check_value("read_value", read_value, exp_rd);
        @(negedge clk);
        enable         = 1'b0;
        is_write_stage = 1'b0;
        apply_update(o, ae, wv);
    endtask

    task automatic read_csr(input logic [2:0] a, output logic [XLEN-1:0] rd);
        run_op(CSRRS, {2'b00, a}, '0, rd);
    endtask

    // Pending outputs lag the register update by one cycle
    task automatic op_with_pending_check(input csr_op_e o, input logic [AE_W-1:0] ae,
                                         input logic [XLEN-1:0] wv);
        logic            old_sw;
        logic            old_ext;
        logic [XLEN-1:0] rd;
        old_sw  = sw_pending_expected();
        old_ext = ext_pending_expected();
        run_op(o, ae, wv, rd);
        check_flag("sw_int_pending", sw_int_pending, old_sw);
        check_flag("ext_int_pending", ext_int_pending, old_ext);
        @(negedge clk);
        check_pending();
    endtask

    task automatic pulse_ext_int();
        logic old_ext;
        old_ext = ext_pending_expected();
        @(negedge clk);
        ext_int = 1'b1;
        @(negedge clk);
        ext_int = 1'b0;
        check_flag("ext_int_pending", ext_int_pending, old_ext);
        m_mip[MIP_EXT_BIT] = 1'b1;
        @(negedge clk);
        check_pending();
    endtask

    task automatic after_reset();
        logic [XLEN-1:0] rd;
        check_flag("sw_int_pending", sw_int_pending, 1'b0);
        check_flag("ext_int_pending", ext_int_pending, 1'b0);
        foreach (reg_list[i]) begin
            read_csr(reg_list[i], rd);
            check_value("register after reset", rd, '0);
        end
    endtask

    task automatic rmw_random();
        logic [XLEN-1:0] rd;
        for (int n = 0; n < 10; n++) begin
            foreach (op_list[k]) begin
                foreach (reg_list[i]) begin
                    run_op(op_list[k], {2'b00, reg_list[i]}, $urandom(), rd);
                end
            end
        end
        foreach (reg_list[i]) begin
            read_csr(reg_list[i], rd);
        end
        foreach (reg_list[i]) begin
            run_op(CSRRW, {2'b00, reg_list[i]}, '0, rd);
        end
    endtask

    task automatic exception_entry();
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] pc;
        pc = $urandom() | 32'h3; // Misaligned pc
        run_op(CSRRW, {2'b00, MSTATUS}, 32'h0000_0008, rd);
        run_op(EXCEPTION, 5'h02, pc, rd);
        check_value("handler address", rd, HANDLER_VALUE);
        read_csr(MEPC, rd);
        check_value("mepc after entry", rd, {pc[31:2], 2'b00});
        read_csr(MCAUSE, rd);
        check_value("mcause after entry", rd, 32'h0000_0002);
        read_csr(MSTATUS, rd);
        check_value("mstatus after entry", rd, 32'h0000_0080);
    endtask

    task automatic mret_return();
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] epc;
        epc = m_mepc; // pc saved by the last entry
        run_op(MRET, '0, '0, rd);
        check_value("mret read", rd, epc);
        read_csr(MSTATUS, rd);
        check_value("mstatus after mret", rd, 32'h0000_0088);
    endtask

    task automatic interrupt_pending();
        logic [XLEN-1:0] rd;
        run_op(CSRRW, {2'b00, MIE}, '0, rd);
        run_op(CSRRW, {2'b00, MIP}, '0, rd);
        op_with_pending_check(CSRRW, {2'b00, MSTATUS}, 32'h0000_0008);
        pulse_ext_int(); // mie still clear
        read_csr(MIP, rd);
        check_value("mip after ext_int", rd, 32'h0000_0800);
        op_with_pending_check(CSRRW, {2'b00, MIE}, 32'h0000_0808);
        op_with_pending_check(EXCEPTION, {1'b1, EXT_INT_CODE}, 32'h0000_2000);
        read_csr(MIP, rd);
        check_value("mip after external trap", rd, '0);
        op_with_pending_check(CSRRW, {2'b00, MSTATUS}, 32'h0000_0008);
        pulse_ext_int();
        op_with_pending_check(CSRRC, {2'b00, MIP}, 32'h0000_0800);
        op_with_pending_check(CSRRS, {2'b00, MIP}, 32'h0000_0008);
        op_with_pending_check(EXCEPTION, {1'b1, SW_INT_CODE}, 32'h0000_3000);
        read_csr(MIP, rd);
        check_value("mip after software trap", rd, '0);
        read_csr(MCAUSE, rd);
        check_value("mcause after software trap", rd, 32'h8000_0003);
    endtask

    task automatic enable_low_hold();
        logic [XLEN-1:0] held;
        logic [XLEN-1:0] rd;
        read_csr(MCAUSE, rd);
        held = m_mcause;
        @(negedge clk);
        ext_int        = 1'b1;
        enable         = 1'b0;
        is_write_stage = 1'b0;
        op             = CSRRW;
        addr_exception = {2'b00, MSTATUS};
        write_value    = '1;
        @(negedge clk);
        ext_int        = 1'b0;
        is_write_stage = 1'b1;
        check_value("read_value with enable low", read_value, held);
        @(negedge clk);
        is_write_stage = 1'b0;
        op             = EXCEPTION;
        addr_exception = {1'b1, EXT_INT_CODE};
        @(negedge clk);
        is_write_stage = 1'b1;
        @(negedge clk);
        is_write_stage = 1'b0;
        check_value("read_value with enable low", read_value, held);
        m_mip[MIP_EXT_BIT] = 1'b1; // Captured anyway
        foreach (reg_list[i]) begin
            read_csr(reg_list[i], rd);
        end
        @(negedge clk);
        check_pending();
    endtask

    initial begin
        error_count    = 0;
        check_count    = 0;
        void'($urandom(93));
        reg_list       = '{MSTATUS, MIE, MEPC, MCAUSE, MIP};
        op_list        = '{CSRRW, CSRRS, CSRRC};
        reset          = 1'b1;
        enable         = 1'b0;
        is_write_stage = 1'b0;
        op             = CSRRS;
        addr_exception = '0;
        write_value    = '0;
        ext_int        = 1'b0;
        clear_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        after_reset();
        rmw_random();
        exception_entry();
        mret_return();
        interrupt_pending();
        enable_low_hold();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  logic            enable,
    input  logic            is_write_stage,
    input  csr_op_e         op,
    input  logic [AE_W-1:0] addr_exception,
    output logic            read_load,
    output logic            save_enable,
    output csr_addr_e       read_sel,
    output rmw_mode_e       rmw_mode,
    output logic            wr_mstatus,
    output logic            wr_mie,
    output logic            wr_mepc,
    output logic            wr_mcause,
    output logic            wr_mip,
    output logic            trap_enter,
    output logic            trap_return,
    output logic            clear_sw,
    output logic            clear_ext
);

    logic      op_exc;
    logic      op_mret;
    logic      op_csr;
    logic      rd_en;
    logic      wr_en;
    logic      is_int;
    csr_addr_e csr_addr;

    assign op_exc   = (op == EXCEPTION);
    assign op_mret  = (op == MRET);
    assign op_csr   = (op == CSRRW) || (op == CSRRS) || (op == CSRRC);
    assign csr_addr = csr_addr_e'(addr_exception[2:0]);
    assign is_int   = addr_exception[AE_INT_BIT];

    assign rd_en = enable & ~is_write_stage;
    assign wr_en = enable & is_write_stage;

    always_comb begin
        if (op_exc)
            read_sel = HANDLER;
        else if (op_mret)
            read_sel = MEPC;
        else if (op_csr)
            read_sel = csr_addr;
        else
            read_sel = MSTATUS; // Not loaded, read_load stays low
    end

    always_comb begin
        case (op)
            CSRRS:   rmw_mode = SET;
            CSRRC:   rmw_mode = CLEAR;
            default: rmw_mode = WRITE;
        endcase
    end

    assign read_load   = rd_en & (op_exc | op_mret | op_csr);
    assign save_enable = rd_en & (op_exc | op_mret);

    // Source select for the trap registers, held over both stages
    assign trap_enter  = enable & op_exc;
    assign trap_return = wr_en & op_mret;

    assign wr_mstatus = wr_en & ((op_csr & (csr_addr == MSTATUS)) | op_exc | op_mret);
    assign wr_mepc    = wr_en & ((op_csr & (csr_addr == MEPC)) | op_exc);
    assign wr_mcause  = wr_en & ((op_csr & (csr_addr == MCAUSE)) | op_exc);
    assign wr_mie     = wr_en & op_csr & (csr_addr == MIE);
    assign wr_mip     = wr_en & op_csr & (csr_addr == MIP);

    assign clear_sw  = wr_en & op_exc & is_int & (addr_exception[CAUSE_W-1:0] == SW_INT_CODE);
    assign clear_ext = wr_en & op_exc & is_int & (addr_exception[CAUSE_W-1:0] == EXT_INT_CODE);

endmodule

`default_nettype wire

/* hdl/csr_int_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_int_ctrl
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            ext_int,
    input  logic            wr_mie,
    input  logic            wr_mip,
    input  logic            clear_sw,
    input  logic            clear_ext,
    input  logic [XLEN-1:0] rmw_value,
    input  logic            mstatus_ie,
    output logic [XLEN-1:0] mie_q,
    output logic [XLEN-1:0] mip_q,
    output logic            sw_int_pending,
    output logic            ext_int_pending
);

    logic sw_en_q;
    logic ext_en_q;
    logic sw_ip_q;
    logic ext_ip_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            sw_en_q  <= 1'b0;
            ext_en_q <= 1'b0;
        end else if (wr_mie) begin
            sw_en_q  <= rmw_value[MIE_SW_BIT];
            ext_en_q <= rmw_value[MIE_EXT_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sw_ip_q <= 1'b0;
        end else if (clear_sw) begin
            sw_ip_q <= 1'b0;
        end else if (wr_mip) begin
            sw_ip_q <= rmw_value[MIP_SW_BIT];
        end
    end

    // ext_int is sampled every cycle and beats any clear
    always_ff @(posedge clk) begin
        if (reset) begin
            ext_ip_q <= 1'b0;
        end else if (ext_int) begin
            ext_ip_q <= 1'b1;
        end else if (clear_ext) begin
            ext_ip_q <= 1'b0;
        end else if (wr_mip) begin
            ext_ip_q <= rmw_value[MIP_EXT_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sw_int_pending  <= 1'b0;
            ext_int_pending <= 1'b0;
        end else begin
            sw_int_pending  <= sw_ip_q & sw_en_q & mstatus_ie;
            ext_int_pending <= ext_ip_q & ext_en_q & mstatus_ie;
        end
    end

    always_comb begin
        mie_q              = '0;
        mie_q[MIE_SW_BIT]  = sw_en_q;
        mie_q[MIE_EXT_BIT] = ext_en_q;
        mip_q              = '0;
        mip_q[MIP_SW_BIT]  = sw_ip_q;
        mip_q[MIP_EXT_BIT] = ext_ip_q;
    end

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int XLEN    = 32;
    localparam int CAUSE_W = 4;

    // addr_exception layout: interrupt flag on top of the cause code
    localparam int AE_W       = 5;
    localparam int AE_INT_BIT = 4;

    typedef enum logic [2:0] {
        EXCEPTION = 3'b000,
        MRET      = 3'b001,
        CSRRW     = 3'b101,
        CSRRS     = 3'b110,
        CSRRC     = 3'b111
    } csr_op_e;

    // Mapped register index, unlisted codes read as zero
    typedef enum logic [2:0] {
        MSTATUS = 3'd0,
        HANDLER = 3'd2, // Read-only handler address
        MIE     = 3'd3,
        MEPC    = 3'd5,
        MCAUSE  = 3'd6,
        MIP     = 3'd7
    } csr_addr_e;

    typedef enum logic [1:0] {
        WRITE = 2'd0,
        SET   = 2'd1,
        CLEAR = 2'd2
    } rmw_mode_e;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIE_SW_BIT       = 3;
    localparam int MIE_EXT_BIT      = 11;
    localparam int MIP_SW_BIT       = 3;
    localparam int MIP_EXT_BIT      = 11;
    localparam int MCAUSE_INT_BIT   = 31;

    // Interrupt cause codes
    localparam logic [CAUSE_W-1:0] SW_INT_CODE  = 4'd3;
    localparam logic [CAUSE_W-1:0] EXT_INT_CODE = 4'd11;

endpackage

`default_nettype wire

/* hdl/csr_read_path.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_read_path
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] HANDLER_ADDR = XLEN'(16)
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            read_load,
    input  logic            save_enable,
    input  logic            trap_enter,
    input  csr_addr_e       read_sel,
    input  rmw_mode_e       rmw_mode,
    input  logic [XLEN-1:0] write_value,
    input  logic [XLEN-1:0] mstatus_q,
    input  logic [XLEN-1:0] mie_q,
    input  logic [XLEN-1:0] mepc_q,
    input  logic [XLEN-1:0] mcause_q,
    input  logic [XLEN-1:0] mip_q,
    output logic [XLEN-1:0] read_value,
    output logic [XLEN-1:0] rmw_value,
    output logic            saved_ie
);

    logic [XLEN-1:0] sel_value;

    always_comb begin
        case (read_sel)
            MSTATUS: sel_value = mstatus_q;
            HANDLER: sel_value = HANDLER_ADDR;
            MIE:     sel_value = mie_q;
            MEPC:    sel_value = mepc_q;
            MCAUSE:  sel_value = mcause_q;
            MIP:     sel_value = mip_q;
            default: sel_value = '0;
        endcase
    end

    // New register value for CSR ops, used in the write stage
    always_comb begin
        case (rmw_mode)
            SET:     rmw_value = sel_value | write_value;
            CLEAR:   rmw_value = sel_value & ~write_value;
            default: rmw_value = write_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            read_value <= '0;
        end else if (read_load) begin
            read_value <= sel_value;
        end
    end

    // Enable bit carried from the read stage into the write stage
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_ie <= 1'b0;
        end else if (save_enable) begin
            if (trap_enter)
                saved_ie <= mstatus_q[MSTATUS_MIE_BIT];
            else
                saved_ie <= mstatus_q[MSTATUS_MPIE_BIT]; // mret
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_trap_state.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_state
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            wr_mstatus,
    input  logic            wr_mepc,
    input  logic            wr_mcause,
    input  logic            trap_enter,
    input  logic            trap_return,
    input  logic [XLEN-1:0] rmw_value,
    input  logic [XLEN-1:0] write_value,
    input  logic [AE_W-1:0] addr_exception,
    input  logic            saved_ie,
    output logic [XLEN-1:0] mstatus_q,
    output logic [XLEN-1:0] mepc_q,
    output logic [XLEN-1:0] mcause_q
);

    logic               ie_q;
    logic               pie_q;
    logic [XLEN-1:2]    epc_q;
    logic               cause_int_q;
    logic [CAUSE_W-1:0] cause_code_q;

    // mstatus holds only MIE and MPIE
    always_ff @(posedge clk) begin
        if (reset) begin
            ie_q  <= 1'b0;
            pie_q <= 1'b0;
        end else if (wr_mstatus) begin
            if (trap_enter) begin
                ie_q  <= 1'b0;
                pie_q <= saved_ie;
            end else if (trap_return) begin
                ie_q <= saved_ie; // MPIE kept
            end else begin
                ie_q  <= rmw_value[MSTATUS_MIE_BIT];
                pie_q <= rmw_value[MSTATUS_MPIE_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc_q <= '0;
        end else if (wr_mepc) begin
            if (trap_enter)
                epc_q <= write_value[XLEN-1:2]; // Faulting pc
            else
                epc_q <= rmw_value[XLEN-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_int_q  <= 1'b0;
            cause_code_q <= '0;
        end else if (wr_mcause) begin
            if (trap_enter) begin
                cause_int_q  <= addr_exception[AE_INT_BIT];
                cause_code_q <= addr_exception[CAUSE_W-1:0];
            end else begin
                cause_int_q  <= rmw_value[MCAUSE_INT_BIT];
                cause_code_q <= rmw_value[CAUSE_W-1:0];
            end
        end
    end

    always_comb begin
        mstatus_q                   = '0;
        mstatus_q[MSTATUS_MIE_BIT]  = ie_q;
        mstatus_q[MSTATUS_MPIE_BIT] = pie_q;
    end

    assign mepc_q = {epc_q, 2'b00};

    always_comb begin
        mcause_q                 = '0;
        mcause_q[MCAUSE_INT_BIT] = cause_int_q;
        mcause_q[CAUSE_W-1:0]    = cause_code_q;
    end

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter logic [XLEN-1:0] HANDLER_ADDR = XLEN'(16)
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  logic            is_write_stage,
    input  csr_op_e         op,
    input  logic [AE_W-1:0] addr_exception,
    input  logic [XLEN-1:0] write_value,
    input  logic            ext_int,
    output logic [XLEN-1:0] read_value,
    output logic            sw_int_pending,
    output logic            ext_int_pending
);

    logic            read_load;
    logic            save_enable;
    csr_addr_e       read_sel;
    rmw_mode_e       rmw_mode;
    logic            wr_mstatus;
    logic            wr_mie;
    logic            wr_mepc;
    logic            wr_mcause;
    logic            wr_mip;
    logic            trap_enter;
    logic            trap_return;
    logic            clear_sw;
    logic            clear_ext;
    logic [XLEN-1:0] rmw_value;
    logic            saved_ie;
    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mip_q;

    csr_decode u_decode (
        .enable         (enable),
        .is_write_stage (is_write_stage),
        .op             (op),
        .addr_exception (addr_exception),
        .read_load      (read_load),
        .save_enable    (save_enable),
        .read_sel       (read_sel),
        .rmw_mode       (rmw_mode),
        .wr_mstatus     (wr_mstatus),
        .wr_mie         (wr_mie),
        .wr_mepc        (wr_mepc),
        .wr_mcause      (wr_mcause),
        .wr_mip         (wr_mip),
        .trap_enter     (trap_enter),
        .trap_return    (trap_return),
        .clear_sw       (clear_sw),
        .clear_ext      (clear_ext)
    );

    csr_read_path #(
        .HANDLER_ADDR (HANDLER_ADDR)
    ) u_read_path (
        .clk         (clk),
        .reset       (reset),
        .read_load   (read_load),
        .save_enable (save_enable),
        .trap_enter  (trap_enter),
        .read_sel    (read_sel),
        .rmw_mode    (rmw_mode),
        .write_value (write_value),
        .mstatus_q   (mstatus_q),
        .mie_q       (mie_q),
        .mepc_q      (mepc_q),
        .mcause_q    (mcause_q),
        .mip_q       (mip_q),
        .read_value  (read_value),
        .rmw_value   (rmw_value),
        .saved_ie    (saved_ie)
    );

    csr_trap_state u_trap_state (
        .clk            (clk),
        .reset          (reset),
        .wr_mstatus     (wr_mstatus),
        .wr_mepc        (wr_mepc),
        .wr_mcause      (wr_mcause),
        .trap_enter     (trap_enter),
        .trap_return    (trap_return),
        .rmw_value      (rmw_value),
        .write_value    (write_value),
        .addr_exception (addr_exception),
        .saved_ie       (saved_ie),
        .mstatus_q      (mstatus_q),
        .mepc_q         (mepc_q),
        .mcause_q       (mcause_q)
    );

    csr_int_ctrl u_int_ctrl (
        .clk             (clk),
        .reset           (reset),
        .ext_int         (ext_int),
        .wr_mie          (wr_mie),
        .wr_mip          (wr_mip),
        .clear_sw        (clear_sw),
        .clear_ext       (clear_ext),
        .rmw_value       (rmw_value),
        .mstatus_ie      (mstatus_q[MSTATUS_MIE_BIT]),
        .mie_q           (mie_q),
        .mip_q           (mip_q),
        .sw_int_pending  (sw_int_pending),
        .ext_int_pending (ext_int_pending)
    );

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_read_path.sv
hdl/csr_trap_state.sv
hdl/csr_int_ctrl.sv
hdl/csr_unit.sv
dv/tb_csr_unit.sv
